// ==== lsu_top.f ====
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_wb_if.sv
logic/lsu_req_gen.sv
logic/lsu_txn_tracker.sv
logic/lsu_rdata_align.sv
logic/lsu_top.sv
dv/lsu_clk_gen.sv
dv/lsu_mem_model.sv
dv/lsu_tb.sv

// ==== dv/lsu_tb.sv ====
/*
 * LSU testbench
 * Table of loads and stores against a memory model including split accesses
 */

`include "lsu_params.svh"

module lsu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_PERIOD       = 10;
  localparam int          RESET_CYCLES     = 8;
  localparam int          CYCLES_PER_ENTRY = 40;
  localparam int unsigned SEED             = 69445;
  localparam logic        ST               = 1'b1;
  localparam logic        LD               = 1'b0;

  typedef struct {
    logic                   we;
    lsu_pkg::lsu_size_e     size;
    logic                   sign;
    logic [`LSU_DATA_W-1:0] base;
    logic [`LSU_DATA_W-1:0] offset;
    logic [`LSU_DATA_W-1:0] data;
    logic [`LSU_DATA_W-1:0] exp_rdata;   // Loads only
    logic                   exp_err;
  } entry_t;

  entry_t entries[$];

  logic                   clk;
  logic                   rst_n;
  logic                   lsu_en_i;
  logic                   lsu_we_i;
  lsu_pkg::lsu_size_e     lsu_size_i;
  logic                   lsu_sign_ext_i;
  logic                   lsu_second_i;
  logic                   use_incr_i;
  logic [`LSU_DATA_W-1:0] operand_a_i;
  logic [`LSU_DATA_W-1:0] operand_b_i;
  logic [`LSU_DATA_W-1:0] wdata_i;
  logic                   ready_0_o;
  logic                   misaligned_0_o;
  logic                   valid_1_o;
  logic [`LSU_DATA_W-1:0] rdata_1_o;
  logic                   err_1_o;
  logic [`LSU_DATA_W-1:0] addr_1_o;
  logic                   busy_o;
  logic                   data_req_o;
  logic [`LSU_DATA_W-1:0] data_addr_o;
  logic                   data_we_o;
  logic [`LSU_BE_W-1:0]   data_be_o;
  logic [`LSU_DATA_W-1:0] data_wdata_o;
  logic                   data_gnt_i;
  logic                   data_rvalid_i;
  logic [`LSU_DATA_W-1:0] data_rdata_i;
  logic                   data_err_i;

  lsu_clk_gen clk_gen_inst (.clk(clk), .rst_n(rst_n));

  lsu_top lsu_top_inst (.*);

  lsu_mem_model #(.SEED(SEED)) mem_model_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (data_req_o),
    .addr_i   (data_addr_o),
    .we_i     (data_we_o),
    .be_i     (data_be_o),
    .wdata_i  (data_wdata_o),
    .gnt_o    (data_gnt_i),
    .rvalid_o (data_rvalid_i),
    .rdata_o  (data_rdata_i),
    .err_o    (data_err_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reporting

  task automatic stop_run();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("** Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table

  function automatic void add_entry(input logic we, input lsu_pkg::lsu_size_e size,
                                    input logic sign, input logic [31:0] base,
                                    input logic [31:0] offset, input logic [31:0] data,
                                    input logic [31:0] exp_rdata, input logic exp_err);
    entries.push_back(entry_t'{we, size, sign, base, offset, data, exp_rdata, exp_err});
  endfunction

  function automatic void build_table();
    // Aligned word and then every byte and halfword lane of it
    add_entry(ST, lsu_pkg::LSU_WORD, 1'b0, 32'h100, 32'd0, 32'h87E5_C3A1, 32'h0, 1'b0);
    add_entry(LD, lsu_pkg::LSU_WORD, 1'b0, 32'h100, 32'd0, 32'h0, 32'h87E5_C3A1, 1'b0);
    add_entry(LD, lsu_pkg::LSU_BYTE, 1'b1, 32'h100, 32'd0, 32'h0, 32'hFFFF_FFA1, 1'b0);
    add_entry(LD, lsu_pkg::LSU_BYTE, 1'b0, 32'h100, 32'd1, 32'h0, 32'h0000_00C3, 1'b0);
    add_entry(LD, lsu_pkg::LSU_BYTE, 1'b1, 32'h100, 32'd2, 32'h0, 32'hFFFF_FFE5, 1'b0);
    add_entry(LD, lsu_pkg::LSU_BYTE, 1'b1, 32'h100, 32'd3, 32'h0, 32'hFFFF_FF87, 1'b0);
    add_entry(LD, lsu_pkg::LSU_HALF, 1'b1, 32'h100, 32'd0, 32'h0, 32'hFFFF_C3A1, 1'b0);
    add_entry(LD, lsu_pkg::LSU_HALF, 1'b0, 32'h100, 32'd1, 32'h0, 32'h0000_E5C3, 1'b0);
    add_entry(LD, lsu_pkg::LSU_HALF, 1'b1, 32'h100, 32'd2, 32'h0, 32'hFFFF_87E5, 1'b0);
    add_entry(LD, lsu_pkg::LSU_HALF, 1'b0, 32'h100, 32'd2, 32'h0, 32'h0000_87E5, 1'b0);
    // Split stores at offsets 1 to 3 read back aligned and split
    add_entry(ST, lsu_pkg::LSU_WORD, 1'b0, 32'h200, 32'd1, 32'hA1B2_C3D4, 32'h0, 1'b0);
    add_entry(LD, lsu_pkg::LSU_HALF, 1'b0, 32'h200, 32'd2, 32'h0, 32'h0000_B2C3, 1'b0);
    add_entry(LD, lsu_pkg::LSU_BYTE, 1'b1, 32'h200, 32'd4, 32'h0, 32'hFFFF_FFA1, 1'b0);
    // Neighbour bytes keep the fill pattern
    add_entry(LD, lsu_pkg::LSU_WORD, 1'b0, 32'h200, 32'd0, 32'h0, 32'hB2C3_D458, 1'b0);
    add_entry(LD, lsu_pkg::LSU_WORD, 1'b0, 32'h200, 32'd4, 32'h0, 32'h5F5E_5DA1, 1'b0);
    add_entry(LD, lsu_pkg::LSU_WORD, 1'b0, 32'h200, 32'd1, 32'h0, 32'hA1B2_C3D4, 1'b0);
    add_entry(ST, lsu_pkg::LSU_WORD, 1'b0, 32'h300, 32'd2, 32'h1122_3344, 32'h0, 1'b0);
    add_entry(LD, lsu_pkg::LSU_HALF, 1'b0, 32'h300, 32'd2, 32'h0, 32'h0000_3344, 1'b0);
    add_entry(LD, lsu_pkg::LSU_HALF, 1'b1, 32'h300, 32'd4, 32'h0, 32'h0000_1122, 1'b0);
    add_entry(LD, lsu_pkg::LSU_WORD, 1'b0, 32'h300, 32'd2, 32'h0, 32'h1122_3344, 1'b0);
    add_entry(ST, lsu_pkg::LSU_WORD, 1'b0, 32'h400, 32'd3, 32'h8899_AABB, 32'h0, 1'b0);
    add_entry(LD, lsu_pkg::LSU_HALF, 1'b1, 32'h400, 32'd4, 32'h0, 32'hFFFF_99AA, 1'b0);
    add_entry(LD, lsu_pkg::LSU_HALF, 1'b1, 32'h400, 32'd3, 32'h0, 32'hFFFF_AABB, 1'b0);
    add_entry(LD, lsu_pkg::LSU_WORD, 1'b0, 32'h400, 32'd3, 32'h0, 32'h8899_AABB, 1'b0);
    // Error region
    add_entry(LD, lsu_pkg::LSU_WORD, 1'b0, 32'hF000, 32'd0, 32'h0, 32'h0, 1'b1);
    add_entry(LD, lsu_pkg::LSU_BYTE, 1'b0, 32'hF000, 32'd7, 32'h0, 32'h0, 1'b1);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Core-side driver

  task automatic drive_idle();
    lsu_en_i       = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_size_i     = lsu_pkg::LSU_BYTE;
    lsu_sign_ext_i = 1'b0;
    lsu_second_i   = 1'b0;
    use_incr_i     = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    wdata_i        = '0;
  endtask

  task automatic drive_phase(input entry_t e, input logic second);
    lsu_en_i       = 1'b1;
    lsu_we_i       = e.we;
    lsu_size_i     = e.size;
    lsu_sign_ext_i = e.sign;
    lsu_second_i   = second;
    use_incr_i     = 1'b1;
    operand_a_i    = e.base;
    operand_b_i    = second ? e.offset + 32'd4 : e.offset;   // Second phase hits next word
    wdata_i        = e.data;
  endtask

  // Hold the phase until the bus takes it and see ready_0_o only in the grant cycle
  task automatic wait_grant(input logic exp_mis);
    logic accept;
    accept = 1'b0;
    while (!accept)
    begin
      @(negedge clk);
      accept = data_req_o && data_gnt_i;
      check_value("misaligned_0_o", misaligned_0_o, exp_mis);
      check_value("ready_0_o", ready_0_o, accept);
      check_value("valid_1_o", valid_1_o, 1'b0);   // Nothing final yet
    end
  endtask

  task automatic wait_response();
    do
      @(negedge clk);
    while (!valid_1_o);
  endtask

  // Called at a rising edge and returns at a rising edge
  task automatic run_entry(input entry_t e);
    logic [31:0] addr;
    logic        split;
    logic [31:0] last_addr;
    addr      = e.base + e.offset;
    split     = ((e.size == lsu_pkg::LSU_WORD) && (addr[1:0] != 2'b00)) ||
                ((e.size == lsu_pkg::LSU_HALF) && (addr[1:0] == 2'b11));
    last_addr = {addr[31:2], 2'b00} + (split ? 32'd4 : 32'd0);
    #1;
    drive_phase(e, 1'b0);
    wait_grant(split);
    if (split)
    begin
      @(posedge clk);
      #1;
      drive_phase(e, 1'b1);
      wait_grant(1'b0);
    end
    @(posedge clk);
    #1;
    drive_idle();
    wait_response();
    check_value("err_1_o", err_1_o, e.exp_err);
    check_value("addr_1_o", addr_1_o, last_addr);
    if (!e.we && !e.exp_err)
      check_value("rdata_1_o", rdata_1_o, e.exp_rdata);
    @(posedge clk);
    @(negedge clk);
    check_value("busy_o", busy_o, 1'b0);
    @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence, monitor and watchdog

  initial
  begin
    build_table();
    drive_idle();
    wait (rst_n);
    @(negedge clk);
    check_value("data_req_o", data_req_o, 1'b0);        // Idle state after reset
    check_value("valid_1_o", valid_1_o, 1'b0);
    check_value("misaligned_0_o", misaligned_0_o, 1'b0);
    check_value("busy_o", busy_o, 1'b0);
    check_value("ready_0_o", ready_0_o, 1'b1);
    @(posedge clk);
    foreach (entries[i])
      run_entry(entries[i]);
    $display("SIMULATION PASSED");
    $finish;
  end

  // No bus request without an access strobe
  always @(negedge clk)
    if (rst_n)
      check_value("data_req_o without lsu_en_i", data_req_o && !lsu_en_i, 1'b0);

  initial
  begin
    int unsigned limit_ns;
    #1;                                  // Table is built by now
    limit_ns = (entries.size() * CYCLES_PER_ENTRY + 2 * RESET_CYCLES) * CLK_PERIOD;
    #(limit_ns);
    $display("Timeout: the test table did not finish within %0d ns", limit_ns);
    stop_run();
  end

endmodule

// ==== dv/lsu_mem_model.sv ====
/*
 * Data memory model for the LSU bus
 * Random grant delay of 0 to 2 cycles, response one cycle after grant
 */

`include "lsu_params.svh"

module lsu_mem_model #(
  parameter int unsigned SEED = 1
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic [`LSU_DATA_W-1:0] addr_i,
  input  logic                   we_i,
  input  logic [`LSU_BE_W-1:0]   be_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output logic [`LSU_DATA_W-1:0] rdata_o,
  output logic                   err_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0]          mem [0:65535];   // 64 KiB, byte addressed
  logic [1:0]          gnt_wait;        // Cycles left before the next grant
  logic                accept;
  logic                bad_addr;
  lsu_pkg::lsu_rword_u wword;
  lsu_pkg::lsu_rword_u rword;

  assign gnt_o = req_i && (gnt_wait == 2'd0);
  assign wword = wdata_i;

  initial
  begin
    void'($urandom(SEED));
    for (int a = 0; a < 65536; a++)
      mem[a] = a[7:0] ^ a[15:8] ^ 8'h5A;  // Pattern over the whole address
    gnt_wait = 2'($urandom % 3);
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    forever
    begin
      @(posedge clk);
      accept   = req_i && gnt_o;
      bad_addr = addr_i >= 32'h0000_F000;   // Error region
      if (!rst_n)
      begin
        rvalid_o <= 1'b0;
        err_o    <= 1'b0;
      end
      else
      begin
        rvalid_o <= accept;
        err_o    <= accept && bad_addr;
        if (accept)
        begin
          for (int i = 0; i < `LSU_BE_W; i++)
          begin
            rword.b[i] = mem[{addr_i[15:2], i[1:0]}];    // Word aligned access
            if (we_i && be_i[i] && !bad_addr)
              mem[{addr_i[15:2], i[1:0]}] = wword.b[i];
          end
          rdata_o  <= rword;
          gnt_wait <= 2'($urandom % 3);   // Delay for the next request
        end
        else if (req_i && (gnt_wait != 2'd0))
          gnt_wait <= gnt_wait - 2'd1;
      end
    end
  end

endmodule

// ==== dv/lsu_clk_gen.sv ====
/*
 * Testbench clock and reset
 * 10 ns clock, active-low reset held for 8 cycles
 */

module lsu_clk_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 8;

  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Release just after an edge, away from the DUT's sampling point
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

// ==== logic/lsu_top.sv ====
/*
 * Load/store unit top
 * Request generation, transaction tracking and read alignment
 */

`include "lsu_params.svh"

module lsu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // Core side
  input  logic                   lsu_en_i,
  input  logic                   lsu_we_i,
  input  lsu_pkg::lsu_size_e     lsu_size_i,
  input  logic                   lsu_sign_ext_i,
  input  logic                   lsu_second_i,
  input  logic                   use_incr_i,
  input  logic [`LSU_DATA_W-1:0] operand_a_i,
  input  logic [`LSU_DATA_W-1:0] operand_b_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  output logic                   ready_0_o,
  output logic                   misaligned_0_o,
  output logic                   valid_1_o,
  output logic [`LSU_DATA_W-1:0] rdata_1_o,
  output logic                   err_1_o,
  output logic [`LSU_DATA_W-1:0] addr_1_o,
  output logic                   busy_o,
  // Data bus
  output logic                   data_req_o,
  output logic [`LSU_DATA_W-1:0] data_addr_o,
  output logic                   data_we_o,
  output logic [`LSU_BE_W-1:0]   data_be_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  input  logic                   data_err_i
);

  logic req_allow;

  lsu_wb_if wb_if ();

  lsu_req_gen req_gen_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .lsu_en_i       (lsu_en_i),
    .lsu_we_i       (lsu_we_i),
    .lsu_size_i     (lsu_size_i),
    .lsu_second_i   (lsu_second_i),
    .use_incr_i     (use_incr_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .wdata_i        (wdata_i),
    .req_allow_i    (req_allow),
    .gnt_i          (data_gnt_i),
    .req_o          (data_req_o),
    .addr_o         (data_addr_o),
    .we_o           (data_we_o),
    .be_o           (data_be_o),
    .wdata_o        (data_wdata_o),
    .misaligned_0_o (misaligned_0_o)
  );

  lsu_txn_tracker txn_tracker_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .lsu_en_i       (lsu_en_i),
    .lsu_size_i     (lsu_size_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .lsu_we_i       (lsu_we_i),
    .misaligned_0_i (misaligned_0_o),
    .lsu_second_i   (lsu_second_i),
    .addr_i         (data_addr_o),
    .gnt_i          (data_gnt_i),
    .req_i          (data_req_o),
    .rvalid_i       (data_rvalid_i),
    .err_i          (data_err_i),
    .req_allow_o    (req_allow),
    .ready_0_o      (ready_0_o),
    .valid_1_o      (valid_1_o),
    .err_1_o        (err_1_o),
    .addr_1_o       (addr_1_o),
    .busy_o         (busy_o),
    .wb             (wb_if.tracker)
  );

  lsu_rdata_align rdata_align_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .rdata_i        (data_rdata_i),
    .rdata_1_o      (rdata_1_o),
    .wb             (wb_if.align)
  );

endmodule

// ==== logic/lsu_rdata_align.sv ====
/*
 * LSU read data alignment
 * Lane select, sign or zero extend, and merge of split loads
 */

`include "lsu_params.svh"

module lsu_rdata_align (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`LSU_DATA_W-1:0] rdata_i,
  output logic [`LSU_DATA_W-1:0] rdata_1_o,
  lsu_wb_if.align                wb
);

  lsu_pkg::lsu_rword_u    resp;
  lsu_pkg::lsu_rword_u    rdata_q;              // Raw first half or last result
  logic [7:0]             b_sel;
  logic [15:0]            h_sel;
  logic [`LSU_DATA_W-1:0] w_sel;
  logic [`LSU_DATA_W-1:0] rdata_ext;

  assign resp = rdata_i;

  assign b_sel = resp.b[wb.offset];

  // Halfword lane, offset 3 borrows top byte of saved word
  always_comb
  begin
    case (wb.offset)
      2'b00:   h_sel = resp.h[0];
      2'b01:   h_sel = {resp.b[2], resp.b[1]};
      2'b10:   h_sel = resp.h[1];
      default: h_sel = {resp.b[0], rdata_q.b[3]};
    endcase
  end

  // Word merge, new low bytes on top of saved high bytes
  always_comb
  begin
    case (wb.offset)
      2'b00:   w_sel = resp;
      2'b01:   w_sel = {resp.b[0], rdata_q.b[3], rdata_q.b[2], rdata_q.b[1]};
      2'b10:   w_sel = {resp.h[0], rdata_q.h[1]};
      default: w_sel = {resp.b[2], resp.b[1], resp.b[0], rdata_q.b[3]};
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Extension
  always_comb
  begin
    case (wb.size)
      lsu_pkg::LSU_BYTE:
        rdata_ext = {{(`LSU_DATA_W-8){wb.sign_ext && b_sel[7]}}, b_sel};
      lsu_pkg::LSU_HALF:
        rdata_ext = {{(`LSU_DATA_W-16){wb.sign_ext && h_sel[15]}}, h_sel};
      default:
        rdata_ext = w_sel;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (wb.resp_valid && !wb.we)
    begin
      if (wb.first_phase)
        rdata_q <= resp;                        // Keep high bytes for the merge
      else
        rdata_q <= rdata_ext;
    end
  end

  assign rdata_1_o = wb.resp_valid ? rdata_ext : rdata_q;

  // Split responses only for accesses that actually cross a word
  split_only_unaligned_a: assert property (@(posedge clk) disable iff (!rst_n)
    wb.resp_valid && !wb.last |->
      ((wb.size == lsu_pkg::LSU_WORD) && (wb.offset != 2'b00)) ||
      ((wb.size == lsu_pkg::LSU_HALF) && (wb.offset == 2'b11)))
    else $error("First-phase response for an aligned access");

endmodule

// ==== logic/lsu_txn_tracker.sv ====
/*
 * LSU transaction tracker
 * Outstanding count, EX/WB handshakes, write-back control capture
 */

`include "lsu_params.svh"

module lsu_txn_tracker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   lsu_en_i,
  input  lsu_pkg::lsu_size_e     lsu_size_i,
  input  logic                   lsu_sign_ext_i,
  input  logic                   lsu_we_i,
  input  logic                   misaligned_0_i,
  input  logic                   lsu_second_i,
  input  logic [`LSU_DATA_W-1:0] addr_i,        // Request address as on the bus
  input  logic                   gnt_i,
  input  logic                   req_i,
  input  logic                   rvalid_i,
  input  logic                   err_i,
  output logic                   req_allow_o,
  output logic                   ready_0_o,
  output logic                   valid_1_o,
  output logic                   err_1_o,
  output logic [`LSU_DATA_W-1:0] addr_1_o,
  output logic                   busy_o,
  lsu_wb_if.tracker              wb
);

  logic [`LSU_CNT_W-1:0] cnt_q;
  logic [`LSU_CNT_W-1:0] cnt_d;
  logic                  accept;                // Request granted this cycle
  logic                  last_q;

  assign accept      = req_i && gnt_i;
  assign req_allow_o = cnt_q < `LSU_MAX_OUTSTANDING;

  // Up on grant, down on response, both cancel out
  always_comb
  begin
    case ({accept, rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write-back control, taken on every grant
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q       <= '0;
      wb.size     <= lsu_pkg::LSU_BYTE;
      wb.sign_ext <= 1'b0;
      wb.we       <= 1'b0;
      wb.offset   <= 2'b00;
      last_q      <= 1'b0;
      addr_1_o    <= '0;
    end
    else
    begin
      cnt_q <= cnt_d;
      if (accept)
      begin
        wb.size     <= lsu_size_i;
        wb.sign_ext <= lsu_sign_ext_i;
        wb.we       <= lsu_we_i;
        if (!lsu_second_i)
          wb.offset <= addr_i[1:0];             // Second phase keeps original offset
        last_q      <= !misaligned_0_i;         // First half of a split is not last
        addr_1_o    <= {addr_i[`LSU_DATA_W-1:2], 2'b00};
      end
    end
  end

  assign wb.last        = last_q;
  assign wb.resp_valid  = rvalid_i;
  assign wb.first_phase = rvalid_i && !last_q;

  // EX ready: no access, or grant with WB free / WB draining in lockstep
  always_comb
  begin
    if (!lsu_en_i)
      ready_0_o = 1'b1;
    else
      case (cnt_q)
        2'd0:    ready_0_o = accept;
        2'd1:    ready_0_o = accept && rvalid_i;
        default: ready_0_o = rvalid_i;
      endcase
  end

  assign valid_1_o = (cnt_q != '0) && last_q && rvalid_i;   // Only last phase
  assign err_1_o   = rvalid_i && err_i;
  assign busy_o    = (cnt_q != '0) || req_i;

  cnt_max_a: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= `LSU_MAX_OUTSTANDING)
    else $error("Outstanding count above limit");

  // Every rvalid must answer an earlier grant
  no_orphan_rvalid_a: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> cnt_q != '0)
    else $error("rvalid with nothing outstanding");

endmodule

// ==== logic/lsu_req_gen.sv ====
/*
 * LSU request generation
 * Effective address, misalignment detect, byte enables, store rotation
 */

`include "lsu_params.svh"

module lsu_req_gen (
  input  logic                   clk,           // Only for the bus check below
  input  logic                   rst_n,
  input  logic                   lsu_en_i,
  input  logic                   lsu_we_i,
  input  lsu_pkg::lsu_size_e     lsu_size_i,
  input  logic                   lsu_second_i,  // Second phase of split access
  input  logic                   use_incr_i,
  input  logic [`LSU_DATA_W-1:0] operand_a_i,   // Base
  input  logic [`LSU_DATA_W-1:0] operand_b_i,   // Offset
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  input  logic                   req_allow_i,   // Room for another outstanding
  input  logic                   gnt_i,
  output logic                   req_o,
  output logic [`LSU_DATA_W-1:0] addr_o,
  output logic                   we_o,
  output logic [`LSU_BE_W-1:0]   be_o,
  output logic [`LSU_DATA_W-1:0] wdata_o,
  output logic                   misaligned_0_o
);

  logic [`LSU_DATA_W-1:0] addr_int;
  logic [1:0]             off;

  assign addr_int = use_incr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign off      = addr_int[1:0];

  // Needs a second phase, only flagged on the first one
  assign misaligned_0_o = lsu_en_i && !lsu_second_i &&
                          (((lsu_size_i == lsu_pkg::LSU_WORD) && (off != 2'b00)) ||
                           ((lsu_size_i == lsu_pkg::LSU_HALF) && (off == 2'b11)));

  ////////////////////////////////////////////////////////////////////////////
  // Byte enables
  always_comb
  begin
    case (lsu_size_i)
      lsu_pkg::LSU_BYTE: be_o = 4'b0001 << off;
      lsu_pkg::LSU_HALF:
      begin
        if (lsu_second_i)
          be_o = 4'b0001;                      // Spill byte in next word
        else if (off == 2'b11)
          be_o = 4'b1000;
        else
          be_o = 4'b0011 << off;
      end
      default:
      begin
        if (lsu_second_i)
          be_o = 4'b1111 >> (3'd4 - off);      // Low bytes that wrapped over
        else
          be_o = 4'b1111 << off;
      end
    endcase
  end

  // Rotate store word left by offset bytes, high bytes wrap to low lanes
  always_comb
  begin
    case (off)
      2'b00:   wdata_o = wdata_i;
      2'b01:   wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  // Second phase goes to the next word boundary
  assign addr_o = lsu_second_i ? {addr_int[`LSU_DATA_W-1:2], 2'b00} : addr_int;
  assign we_o   = lsu_we_i;
  assign req_o  = lsu_en_i && req_allow_i;

  // Core must hold its operands while the bus stalls us
  addr_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    req_o && !gnt_i |=> $stable(addr_o))
    else $error("Request address changed before grant");

endmodule

// ==== logic/lsu_wb_if.sv ====
/*
 * Write-back stage control
 * Tracker captures it on grant, read aligner consumes it on rvalid
 */

interface lsu_wb_if;

  lsu_pkg::lsu_size_e size;         // Size of the granted access
  logic               sign_ext;     // Sign extend load result
  logic               we;           // Granted access was a store
  logic [1:0]         offset;       // Byte offset of the original address
  logic               last;         // Response belongs to last phase
  logic               resp_valid;   // Response strobe from bus
  logic               first_phase;  // Response of a split access, first half

  // Tracker owns all fields
  modport tracker (output size, sign_ext, we, offset, last, resp_valid, first_phase);

  // Aligner only looks
  modport align (input size, sign_ext, we, offset, last, resp_valid, first_phase);

endinterface

// ==== logic/lsu_pkg.sv ====
/*
 * Load/store unit types
 * Access size encoding and the two views of a response word
 */

`include "lsu_params.svh"

package lsu_pkg;

  // Access size, same encoding as the core's funct3[1:0]
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  // Response word, seen as byte lanes or as halfword lanes
  typedef union packed {
    logic [`LSU_BE_W-1:0][7:0]     b;   // Byte lane view
    logic [`LSU_BE_W/2-1:0][15:0]  h;   // Halfword lane view
  } lsu_rword_u;

endpackage

// ==== logic/lsu_params.svh ====
/*
 * Load/store unit sizing
 * Data word, byte lanes and outstanding transaction limits
 */

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Data and address word width
`define LSU_DATA_W 32
// One enable per byte lane
`define LSU_BE_W 4
`define LSU_MAX_OUTSTANDING 2 // Granted requests still awaiting rvalid
// Holds 0 up to LSU_MAX_OUTSTANDING
`define LSU_CNT_W 2

`endif
